/* logic/armCtrlPkg.sv */
package armCtrlPkg;

  // ==========================================================
  // Architectural widths
  // ==========================================================
  localparam int InstrWidth = 32;  // ARM instruction word
  localparam int FlagWidth  = 4;   // NZCV
  localparam int MaskWidth  = 4;   // Byte lanes in a word

  // ==========================================================
  // Instruction field positions
  // ==========================================================
  localparam int CondHi   = 31;  // Top bit of the condition field [31:28]
  localparam int OpcodeLo = 21;  // Data processing opcode [24:21]
  localparam int SBit     = 20;  // Set flags
  localparam int UBit     = 23;  // Up/down for load and store offsets
  localparam int BBit     = 22;  // Byte access for LDR/STR
  localparam int LBit     = 20;  // Load when set, store when clear
  localparam int RdLo     = 12;  // Destination register [15:12]

  // Decoded instruction class
  typedef enum logic [2:0] {
    dataImm   = 3'd0,  // Data processing, immediate operand
    dataReg   = 3'd1,  // Data processing, register operand
    multiply  = 3'd2,  // MUL / MLA
    loadStore = 3'd3,  // LDR, STR, LDRB, STRB
    ldStHalf  = 3'd4,  // LDRH, STRH
    branch    = 3'd5,  // B, BL
    undefined = 3'd6   // Nothing this core executes
  } opClassT;

  // Data processing opcodes, encoded as in the instruction
  typedef enum logic [3:0] {
    opAnd = 4'b0000,
    opEor = 4'b0001,
    opSub = 4'b0010,
    opRsb = 4'b0011,
    opAdd = 4'b0100,
    opAdc = 4'b0101,
    opSbc = 4'b0110,
    opRsc = 4'b0111,
    opTst = 4'b1000,  // Compare group starts here, no Rd write
    opTeq = 4'b1001,
    opCmp = 4'b1010,
    opCmn = 4'b1011,
    opOrr = 4'b1100,
    opMov = 4'b1101,
    opBic = 4'b1110,
    opMvn = 4'b1111
  } aluOpT;

  // Condition field
  typedef enum logic [3:0] {
    condEq = 4'b0000,  // Z
    condNe = 4'b0001,  // !Z
    condCs = 4'b0010,  // C
    condCc = 4'b0011,  // !C
    condMi = 4'b0100,  // N
    condPl = 4'b0101,  // !N
    condVs = 4'b0110,  // V
    condVc = 4'b0111,  // !V
    condHi = 4'b1000,  // C and !Z
    condLs = 4'b1001,  // !C or Z
    condGe = 4'b1010,  // N == V
    condLt = 4'b1011,  // N != V
    condGt = 4'b1100,  // !Z and N == V
    condLe = 4'b1101,  // Z or N != V
    condAl = 4'b1110,  // Always
    condNv = 4'b1111   // Never here
  } condT;

endpackage

/* logic/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder
  import armCtrlPkg::*;
(
  input  logic [InstrWidth-1:0] instrD,
  output logic [1:0]            regSrcD,      // [1] Rd as second read, [0] PC as first
  output logic [1:0]            immSrcD,      // Immediate format for the extender
  output logic                  aluSrcD,      // Immediate operand B
  output logic                  memToRegD,
  output logic                  regWriteD,
  output logic                  memWriteD,
  output logic                  branchD,
  output logic                  pcSrcD,       // Writes the PC
  output aluOpT                 aluControlD,
  output logic                  setFlagsD,
  output logic                  byteD,
  output logic                  halfwordD,
  output opClassT               opClassD,
  output logic                  undefinedD
);

  logic [1:0] opField;
  logic       iBit;
  logic       multSig;    // Bits [7:4] == 1001
  logic       halfSig;    // Bit 7 and bit 4 set, SH nonzero
  logic       rsrSig;     // Register-shifted register operand
  logic       psrSpace;   // Compare opcode with S clear, MSR/MRS/BX slots
  logic       isCompare;
  logic [3:0] rdField;
  aluOpT      dpOp;

  assign opField   = instrD[27:26];
  assign iBit      = instrD[25];
  assign dpOp      = aluOpT'(instrD[OpcodeLo +: 4]);
  assign multSig   = (instrD[7:4] == 4'b1001);
  assign halfSig   = instrD[7] & instrD[4] & (instrD[6:5] != 2'b00);
  assign rsrSig    = ~instrD[7] & instrD[4];
  assign isCompare = (dpOp[3:2] == 2'b10);
  assign psrSpace  = isCompare & ~instrD[SBit];

  // ==========================================================
  // Instruction class
  // ==========================================================
  always_comb begin
    opClassD = undefined;
    case (opField)
      2'b00: begin
        if (iBit) begin
          opClassD = psrSpace ? undefined : dataImm;  // MSR immediate lives here
        end else if (multSig) begin
          // Only MUL / MLA, long multiply and swap are not executed
          opClassD = (instrD[24:22] == 3'b000) ? multiply : undefined;
        end else if (halfSig) begin
          opClassD = (instrD[6:5] == 2'b01) ? ldStHalf : undefined;  // No signed loads
        end else if (rsrSig || psrSpace) begin
          opClassD = undefined;
        end else begin
          opClassD = dataReg;
        end
      end
      2'b01:   opClassD = (iBit & instrD[4]) ? undefined : loadStore;  // Architecturally undefined slot
      2'b10:   opClassD = iBit ? branch : undefined;  // Block transfers not supported
      default: opClassD = undefined;  // Coprocessor and SWI
    endcase
  end

  // ==========================================================
  // Main control per class
  // ==========================================================
  always_comb begin
    regSrcD     = 2'b00;
    immSrcD     = 2'b00;
    aluSrcD     = 1'b0;
    memToRegD   = 1'b0;
    regWriteD   = 1'b0;
    memWriteD   = 1'b0;
    branchD     = 1'b0;
    aluControlD = opAdd;  // Address and branch target arithmetic
    setFlagsD   = 1'b0;
    case (opClassD)
      dataImm, dataReg: begin
        aluSrcD     = (opClassD == dataImm);
        regWriteD   = ~isCompare;  // TST/TEQ/CMP/CMN only touch flags
        aluControlD = dpOp;
        setFlagsD   = instrD[SBit];
      end
      multiply: begin
        regWriteD = 1'b1;
      end
      loadStore, ldStHalf: begin
        immSrcD     = (opClassD == ldStHalf) ? 2'b11 : 2'b01;  // Split 8-bit or 12-bit offset
        // Halfword forms carry their immediate flag in bit 22
        aluSrcD     = (opClassD == ldStHalf) ? instrD[22] : ~iBit;
        aluControlD = instrD[UBit] ? opAdd : opSub;
        if (instrD[LBit]) begin
          memToRegD = 1'b1;
          regWriteD = 1'b1;
        end else begin
          regSrcD   = 2'b10;  // Store data comes from Rd
          memWriteD = 1'b1;
        end
      end
      branch: begin
        regSrcD = 2'b01;  // PC as base
        immSrcD = 2'b10;  // 24-bit word offset
        aluSrcD = 1'b1;
        branchD = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // MUL keeps its destination in [19:16]
  assign rdField    = (opClassD == multiply) ? instrD[19:16] : instrD[RdLo +: 4];
  assign pcSrcD     = branchD | (regWriteD & (rdField == 4'hF));
  assign byteD      = (opClassD == loadStore) & instrD[BBit];
  assign halfwordD  = (opClassD == ldStHalf);
  assign undefinedD = (opClassD == undefined);

endmodule

/* logic/condUnit.sv */
`timescale 1ns/1ps

module condUnit
  import armCtrlPkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  condT                 condE,      // Condition of the execute instruction
  input  logic                 setFlagsE,  // S bit, not yet gated
  input  logic                 stallM,
  input  logic [FlagWidth-1:0] aluFlagsE,  // NZCV from the ALU
  output logic                 condExE,    // Condition passes
  output logic [FlagWidth-1:0] flags
);

  logic n;
  logic z;
  logic c;
  logic v;
  logic flagWrite;

  assign {n, z, c, v} = flags;

  // ==========================================================
  // Condition check against the current flags
  // ==========================================================
  always_comb begin
    case (condE)
      condEq:  condExE = z;
      condNe:  condExE = ~z;
      condCs:  condExE = c;
      condCc:  condExE = ~c;
      condMi:  condExE = n;
      condPl:  condExE = ~n;
      condVs:  condExE = v;
      condVc:  condExE = ~v;
      condHi:  condExE = c & ~z;
      condLs:  condExE = ~c | z;
      condGe:  condExE = (n == v);
      condLt:  condExE = (n != v);
      condGt:  condExE = ~z & (n == v);
      condLe:  condExE = z | (n != v);
      condAl:  condExE = 1'b1;
      default: condExE = 1'b0;  // condNv never executes
    endcase
  end

  // Only a passing, flag-setting instruction that really leaves execute
  assign flagWrite = setFlagsE & condExE & ~stallM;

  // ==========================================================
  // NZCV register
  // ==========================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (flagWrite) begin
      flags <= aluFlagsE;  // Visible to the next instruction in execute
    end
  end

endmodule

/* logic/memMask.sv */
`timescale 1ns/1ps

module memMask
  import armCtrlPkg::*;
(
  input  logic                 byteE,      // LDRB / STRB
  input  logic                 halfwordE,  // LDRH / STRH
  input  logic [1:0]           aluAddrE,   // Low address bits
  output logic [MaskWidth-1:0] byteMaskE
);

  logic [MaskWidth-1:0] byteLane;
  logic [MaskWidth-1:0] halfLanes;

  // One-hot lane for a byte access
  assign byteLane = MaskWidth'(1) << aluAddrE;

  // Address bit 1 picks the upper pair
  assign halfLanes = aluAddrE[1] ? 4'b1100 : 4'b0011;

  always_comb begin
    if (byteE) begin
      byteMaskE = byteLane;
    end else if (halfwordE) begin
      byteMaskE = halfLanes;
    end else begin
      byteMaskE = '1;  // Full word
    end
  end

endmodule

/* logic/ctrlPipe.sv */
`timescale 1ns/1ps

module ctrlPipe
  import armCtrlPkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 stallE,
  input  logic                 stallM,
  input  logic                 stallW,
  input  logic                 flushE,
  input  logic                 flushW,
  // Decode stage
  input  logic                 aluSrcD,
  input  logic                 memToRegD,
  input  logic                 regWriteD,
  input  logic                 memWriteD,
  input  logic                 branchD,
  input  logic                 pcSrcD,
  input  aluOpT                aluControlD,
  input  logic                 setFlagsD,
  input  logic                 byteD,
  input  logic                 halfwordD,
  input  condT                 condD,
  // Execute stage feedback
  input  logic                 condExE,
  input  logic [MaskWidth-1:0] byteMaskE,
  // Execute stage
  output logic                 aluSrcE,
  output aluOpT                aluControlE,
  output condT                 condE,
  output logic                 setFlagsRawE,  // Ungated S bit
  output logic                 byteE,
  output logic                 halfwordE,
  output logic                 memToRegE,
  output logic                 branchTakenE,
  // Memory stage
  output logic                 memWriteM,
  output logic                 regWriteM,
  output logic [MaskWidth-1:0] byteMaskM,
  // Writeback stage
  output logic                 memToRegW,
  output logic                 regWriteW,
  output logic                 pcSrcW,
  output logic                 pcWrPendingF
);

  logic regWriteE;
  logic memWriteE;
  logic branchE;
  logic pcSrcE;
  logic memToRegM;
  logic pcSrcM;

  // ==========================================================
  // Execute register
  // ==========================================================
  always_ff @(posedge clk) begin
    if (reset || flushE) begin  // Bubble wins over a stall
      aluSrcE      <= 1'b0;
      aluControlE  <= opAnd;
      condE        <= condEq;
      setFlagsRawE <= 1'b0;
      byteE        <= 1'b0;
      halfwordE    <= 1'b0;
      memToRegE    <= 1'b0;
      regWriteE    <= 1'b0;
      memWriteE    <= 1'b0;
      branchE      <= 1'b0;
      pcSrcE       <= 1'b0;
    end else if (!stallE) begin
      aluSrcE      <= aluSrcD;
      aluControlE  <= aluControlD;
      condE        <= condD;
      setFlagsRawE <= setFlagsD;
      byteE        <= byteD;
      halfwordE    <= halfwordD;
      memToRegE    <= memToRegD;
      regWriteE    <= regWriteD;
      memWriteE    <= memWriteD;
      branchE      <= branchD;
      pcSrcE       <= pcSrcD;
    end
  end

  assign branchTakenE = branchE & condExE;

  // ==========================================================
  // Memory register, side effects gated by the condition
  // ==========================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      memWriteM <= 1'b0;
      regWriteM <= 1'b0;
      pcSrcM    <= 1'b0;
      memToRegM <= 1'b0;
      byteMaskM <= '0;
    end else if (!stallM) begin
      memWriteM <= memWriteE & condExE;
      regWriteM <= regWriteE & condExE;
      pcSrcM    <= pcSrcE & condExE;
      memToRegM <= memToRegE;
      byteMaskM <= byteMaskE;
    end
  end

  // ==========================================================
  // Writeback register
  // ==========================================================
  always_ff @(posedge clk) begin
    if (reset || flushW) begin
      memToRegW <= 1'b0;
      regWriteW <= 1'b0;
      pcSrcW    <= 1'b0;
    end else if (!stallW) begin
      memToRegW <= memToRegM;
      regWriteW <= regWriteM;
      pcSrcW    <= pcSrcM;
    end
  end

  // Fetch must wait while any PC write is in flight
  assign pcWrPendingF = pcSrcD | pcSrcE | pcSrcM;

endmodule

/* logic/armController.sv */
`timescale 1ns/1ps

module armController
  import armCtrlPkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  // Datapath
  input  logic [InstrWidth-1:0] instrD,
  input  logic [FlagWidth-1:0]  aluFlagsE,
  input  logic [1:0]            aluAddrE,
  output logic [1:0]            regSrcD,
  output logic [1:0]            immSrcD,
  output logic                  aluSrcE,
  output aluOpT                 aluControlE,
  output logic                  branchTakenE,
  output logic                  memWriteM,
  output logic [MaskWidth-1:0]  byteMaskM,
  output logic                  memToRegW,
  output logic                  regWriteW,
  output logic                  pcSrcW,
  // Hazard unit
  input  logic                  stallE,
  input  logic                  stallM,
  input  logic                  stallW,
  input  logic                  flushE,
  input  logic                  flushW,
  output logic                  regWriteM,
  output logic                  memToRegE,
  output logic                  pcWrPendingF,
  // Status
  output logic [FlagWidth-1:0]  flags,
  output logic                  undefinedInstr
);

  logic                 aluSrcD;
  logic                 memToRegD;
  logic                 regWriteD;
  logic                 memWriteD;
  logic                 branchD;
  logic                 pcSrcD;
  aluOpT                aluControlD;
  logic                 setFlagsD;
  logic                 byteD;
  logic                 halfwordD;
  condT                 condE;
  logic                 setFlagsE;
  logic                 byteE;
  logic                 halfwordE;
  logic                 condExE;
  logic [MaskWidth-1:0] byteMaskE;

  // ==========================================================
  // Decode
  // ==========================================================
  instrDecoder uDecoder (
    .instrD      (instrD),
    .regSrcD     (regSrcD),
    .immSrcD     (immSrcD),
    .aluSrcD     (aluSrcD),
    .memToRegD   (memToRegD),
    .regWriteD   (regWriteD),
    .memWriteD   (memWriteD),
    .branchD     (branchD),
    .pcSrcD      (pcSrcD),
    .aluControlD (aluControlD),
    .setFlagsD   (setFlagsD),
    .byteD       (byteD),
    .halfwordD   (halfwordD),
    .opClassD    (),             // Class only feeds the undefined flag
    .undefinedD  (undefinedInstr)
  );

  // ==========================================================
  // Stage registers
  // ==========================================================
  ctrlPipe uPipe (
    .clk          (clk),
    .reset        (reset),
    .stallE       (stallE),
    .stallM       (stallM),
    .stallW       (stallW),
    .flushE       (flushE),
    .flushW       (flushW),
    .aluSrcD      (aluSrcD),
    .memToRegD    (memToRegD),
    .regWriteD    (regWriteD),
    .memWriteD    (memWriteD),
    .branchD      (branchD),
    .pcSrcD       (pcSrcD),
    .aluControlD  (aluControlD),
    .setFlagsD    (setFlagsD),
    .byteD        (byteD),
    .halfwordD    (halfwordD),
    .condD        (condT'(instrD[CondHi -: 4])),
    .condExE      (condExE),
    .byteMaskE    (byteMaskE),
    .aluSrcE      (aluSrcE),
    .aluControlE  (aluControlE),
    .condE        (condE),
    .setFlagsRawE (setFlagsE),
    .byteE        (byteE),
    .halfwordE    (halfwordE),
    .memToRegE    (memToRegE),
    .branchTakenE (branchTakenE),
    .memWriteM    (memWriteM),
    .regWriteM    (regWriteM),
    .byteMaskM    (byteMaskM),
    .memToRegW    (memToRegW),
    .regWriteW    (regWriteW),
    .pcSrcW       (pcSrcW),
    .pcWrPendingF (pcWrPendingF)
  );

  // Condition check and NZCV
  condUnit uCond (
    .clk       (clk),
    .reset     (reset),
    .condE     (condE),
    .setFlagsE (setFlagsE),
    .stallM    (stallM),
    .aluFlagsE (aluFlagsE),
    .condExE   (condExE),
    .flags     (flags)
  );

  // Byte lanes for the access in execute
  memMask uMask (
    .byteE     (byteE),
    .halfwordE (halfwordE),
    .aluAddrE  (aluAddrE),
    .byteMaskE (byteMaskE)
  );

endmodule

/* dv/armController_properties.sv */
`timescale 1ns/1ps

module armController_properties
  import armCtrlPkg::*;
(
  input logic                 clk,
  input logic                 reset,
  input logic                 aluSrcE,
  input aluOpT                aluControlE,
  input logic                 memToRegE,
  input logic                 memWriteM,
  input logic                 regWriteM,
  input logic [MaskWidth-1:0] byteMaskM,
  input logic                 memToRegW,
  input logic                 regWriteW,
  input logic                 pcSrcW,
  input logic                 pcWrPendingF,
  input logic [FlagWidth-1:0] flags
);

  // ==========================================================
  // Reset and gating rules
  // ==========================================================
  resetClears: assert property (@(posedge clk)
    reset |=> (!aluSrcE && aluControlE == opAnd && !memToRegE && !memWriteM && !regWriteM &&
               byteMaskM == '0 && !memToRegW && !regWriteW && !pcSrcW && flags == '0))
    else $error("Registered control not cleared after reset");

  // A store never writes the register file
  storeNoRegWrite: assert property (@(posedge clk) disable iff (reset)
    memWriteM |-> !regWriteM)
    else $error("memWriteM and regWriteM high together");

  // PC write reaching writeback was already pending back in execute
  pcWriteAnnounced: assert property (@(posedge clk) disable iff (reset)
    $rose(pcSrcW) |-> $past(pcWrPendingF, 2))
    else $error("pcSrcW rose without pcWrPendingF two cycles before");

endmodule

bind armController armController_properties uProps (
  .clk          (clk),
  .reset        (reset),
  .aluSrcE      (aluSrcE),
  .aluControlE  (aluControlE),
  .memToRegE    (memToRegE),
  .memWriteM    (memWriteM),
  .regWriteM    (regWriteM),
  .byteMaskM    (byteMaskM),
  .memToRegW    (memToRegW),
  .regWriteW    (regWriteW),
  .pcSrcW       (pcSrcW),
  .pcWrPendingF (pcWrPendingF),
  .flags        (flags)
);

/* dv/armControllerTb.sv */
`timescale 1ns/1ps

module armControllerTb;

  // ==========================================================
  // DUT signals
  // ==========================================================
  logic        clk;
  logic        reset;
  logic [31:0] instrD;
  logic [3:0]  aluFlagsE;
  logic [1:0]  aluAddrE;
  logic        stallE;
  logic        stallM;
  logic        stallW;
  logic        flushE;
  logic        flushW;
  logic [1:0]  regSrcD;
  logic [1:0]  immSrcD;
  logic        aluSrcE;
  logic [3:0]  aluControlE;
  logic        branchTakenE;
  logic        memWriteM;
  logic [3:0]  byteMaskM;
  logic        memToRegW;
  logic        regWriteW;
  logic        pcSrcW;
  logic        regWriteM;
  logic        memToRegE;
  logic        pcWrPendingF;
  logic [3:0]  flags;
  logic        undefinedInstr;

  string       goldenLines[$];  // Data lines only, comments dropped
  logic [31:0] f [24];          // Fields of the current line
  int          lineNo;
  int          checks;
  int          errors;
  int          testChecks;
  int          testErrors;
  int          curTag;
  int          cycles;
  int          cycleLimit;      // Zero until the golden file is read

  armController DUT (.*);

  always #10 clk = ~clk;  // 20 ns period

  // Run limit, safety net only
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycleLimit > 0 && cycles >= cycleLimit) begin
      $display("Timeout: run did not finish within %0d cycles", cycleLimit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ==========================================================
  // Helpers
  // ==========================================================
  task automatic readGolden();
    int    fd;
    int    r;
    string line;
    fd = $fopen("dv/controllerGolden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden file dv/controllerGolden.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      r = $fgets(line, fd);
      if (r > 1 && line.getc(0) != "#") begin  // Skip blanks and comment lines
        goldenLines.push_back(line);
      end
    end
    $fclose(fd);
  endtask

  task automatic parseLine(input string line);
    int n;
    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
                f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21],
                f[22], f[23]);
    if (n != 24) begin
      $display("Golden line %0d is malformed, only %0d fields read", lineNo, n);
      errors++;
      testErrors++;
    end
  endtask

  task automatic checkField(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    testChecks++;
    assert (got === exp) else begin
      errors++;
      testErrors++;
      $display("error at %0t ns: line %0d %s is %0h, expected %0h",
               $time, lineNo, name, got, exp);
    end
  endtask

  task automatic reportTest();
    $display("Test %0d done: %0d checks, %0d errors", curTag, testChecks, testErrors);
    testChecks = 0;
    testErrors = 0;
  endtask

  // ==========================================================
  // Main sequence
  // ==========================================================
  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    instrD     = '0;
    aluFlagsE  = '0;
    aluAddrE   = '0;
    stallE     = 1'b0;
    stallM     = 1'b0;
    stallW     = 1'b0;
    flushE     = 1'b0;
    flushW     = 1'b0;
    checks     = 0;
    errors     = 0;
    testChecks = 0;
    testErrors = 0;
    curTag     = 0;
    cycles     = 0;
    cycleLimit = 0;
    lineNo     = 0;

    readGolden();
    if (goldenLines.size() == 0) begin
      $display("The golden file holds no test lines");
      errors++;
    end
    cycleLimit = 2 * goldenLines.size() + 20;

    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;

    foreach (goldenLines[i]) begin
      lineNo = i;
      parseLine(goldenLines[i]);
      if (int'(f[0]) != curTag) begin  // New test group
        if (curTag != 0) begin
          reportTest();
        end
        curTag = int'(f[0]);
      end
      instrD    = f[1];
      aluFlagsE = f[2][3:0];
      aluAddrE  = f[3][1:0];
      stallE    = f[4][0];
      stallM    = f[5][0];
      stallW    = f[6][0];
      flushE    = f[7][0];
      flushW    = f[8][0];
      @(negedge clk);  // Mid cycle, everything settled
      checkField("regSrcD",        32'(regSrcD),        f[9]);
      checkField("immSrcD",        32'(immSrcD),        f[10]);
      checkField("undefinedInstr", 32'(undefinedInstr), f[11]);
      checkField("aluSrcE",        32'(aluSrcE),        f[12]);
      checkField("aluControlE",    32'(aluControlE),    f[13]);
      checkField("branchTakenE",   32'(branchTakenE),   f[14]);
      checkField("memToRegE",      32'(memToRegE),      f[15]);
      checkField("memWriteM",      32'(memWriteM),      f[16]);
      checkField("regWriteM",      32'(regWriteM),      f[17]);
      checkField("byteMaskM",      32'(byteMaskM),      f[18]);
      checkField("memToRegW",      32'(memToRegW),      f[19]);
      checkField("regWriteW",      32'(regWriteW),      f[20]);
      checkField("pcSrcW",         32'(pcSrcW),         f[21]);
      checkField("pcWrPendingF",   32'(pcWrPendingF),   f[22]);
      checkField("flags",          32'(flags),          f[23]);
      @(posedge clk);
      #2;  // Next inputs after the edge
    end
    if (curTag != 0) begin
      reportTest();
    end

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* dv/controllerGolden.txt */
# tag instr fl ad sE sM sW fE fW | expected: rs is ud aS aC bT mE mW rW bm mR wW pW pd fg
# Registered expectations show the state after the edge before the check, all fields hex
1 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 E2821005 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 F 0 0 0 0 0
2 E0443005 0 0 0 0 0 0 0 0 0 0 1 4 0 0 0 0 F 0 0 0 0 0
2 E0060897 0 0 0 0 0 0 0 0 0 0 0 2 0 0 0 1 F 0 0 0 0 0
2 E5921004 0 0 0 0 0 0 0 0 1 0 0 4 0 0 0 1 F 0 1 0 0 0
2 E5021004 0 0 0 0 0 0 0 2 1 0 1 4 0 1 0 1 F 0 1 0 0 0
2 E1C210B2 0 0 0 0 0 0 0 2 3 0 1 2 0 0 0 1 F 0 1 0 0 0
2 EA000010 0 2 0 0 0 0 0 1 2 0 1 4 0 0 1 0 F 1 1 0 1 0
2 E7F000F0 0 0 0 0 0 0 0 0 0 1 1 4 1 0 1 0 C 0 0 0 1 0
3 E3510000 4 0 0 0 0 0 0 0 0 0 0 4 0 0 0 0 F 0 0 0 1 0
3 0A000004 4 0 0 0 0 0 0 1 2 0 1 A 0 0 0 0 F 0 0 1 1 0
3 1A000004 0 0 0 0 0 0 0 1 2 0 1 4 1 0 0 0 F 0 0 0 1 4
3 15021004 0 0 0 0 0 0 0 2 1 0 1 4 0 0 0 0 F 0 0 0 1 4
3 03A00001 0 0 0 0 0 0 0 0 0 0 1 2 0 0 0 0 F 0 0 1 0 4
3 E3510000 0 0 0 0 0 0 0 0 0 0 1 D 0 0 0 0 F 0 0 0 0 4
4 E5C21000 0 0 0 0 0 0 0 2 1 0 1 A 0 0 0 1 F 0 0 0 0 4
4 E5C21000 0 0 1 0 0 0 0 2 1 0 1 4 0 0 0 0 F 0 1 0 0 0
4 E5C21000 0 1 1 0 0 0 0 2 1 0 1 4 0 0 1 0 1 0 0 0 0 0
4 E5C21000 0 2 1 0 0 0 0 2 1 0 1 4 0 0 1 0 2 0 0 0 0 0
4 E5C21000 0 3 1 0 0 0 0 2 1 0 1 4 0 0 1 0 4 0 0 0 0 0
4 E1C210B2 0 0 0 0 0 0 0 2 3 0 1 4 0 0 1 0 8 0 0 0 0 0
4 E1C210B2 0 0 1 0 0 0 0 2 3 0 1 4 0 0 1 0 1 0 0 0 0 0
4 E1C210B2 0 1 1 0 0 0 0 2 3 0 1 4 0 0 1 0 3 0 0 0 0 0
4 E1C210B2 0 2 1 0 0 0 0 2 3 0 1 4 0 0 1 0 3 0 0 0 0 0
4 E1C210B2 0 3 1 0 0 0 0 2 3 0 1 4 0 0 1 0 C 0 0 0 0 0
4 00000000 0 0 0 0 0 0 0 0 0 0 1 4 0 0 1 0 C 0 0 0 0 0
5 EA000010 0 0 0 0 0 0 0 1 2 0 0 0 0 0 1 0 3 0 0 0 1 0
5 00000000 0 0 1 1 1 0 0 0 0 0 1 4 1 0 0 0 F 0 0 0 1 0
5 00000000 0 0 0 0 0 0 0 0 0 0 1 4 1 0 0 0 F 0 0 0 1 0
5 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 F 0 0 0 1 0
5 E2821005 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 F 0 0 1 0 0
5 E1A0F00E 0 0 0 0 0 1 0 0 0 0 1 4 0 0 0 0 F 0 0 0 1 0
5 00000000 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 1 F 0 0 0 0 0
5 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 F 0 0 0 0 0

/* verilog.f */
logic/armCtrlPkg.sv
logic/instrDecoder.sv
logic/condUnit.sv
logic/memMask.sv
logic/ctrlPipe.sv
logic/armController.sv
dv/armController_properties.sv
dv/armControllerTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= armControllerTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
